/* sources.f */
logic/mpmc_pkg.sv
logic/mpmc_req_fifo.sv
logic/mpmc_round_robin.sv
logic/mpmc_state_machine.sv
logic/mpmc_resp_router.sv
logic/mpmc_top.sv
bench/mpmc_monitor.sv
bench/mpmc_checker.sv
bench/mpmc_tb.sv

/* Makefile */
# Verilator simulation of the multi-port memory controller front end

SIM ?= verilator
TOP ?= mpmc_tb
LOG ?= sim.log
BUILD ?= obj_dir
FLIST ?= sources.f
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: SIM TOP LOG BUILD FLIST SIM_FLAGS"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/mpmc_tb.sv */
module mpmc_tb;

	typedef struct {
		string name;
		int ch;
		bit we;
		int blen;
		logic [31:0] adr;
		logic [31:0] sel;
		logic [255:0] data;
	} stim_t;

	localparam int NUM_TESTS = 15;
	// entries queued while calibration is still running
	localparam int RR_ENTRIES = 4;

	// ==================================================
	// stimulus table
	// ==================================================

	stim_t stim [NUM_TESTS] = '{
		'{"rr_ch2", 2, 1'b0, 0, 32'h0000_0400, 32'h0, '0},
		'{"rr_ch0", 0, 1'b0, 0, 32'h0000_0000, 32'h0, '0},
		'{"rr_ch3", 3, 1'b0, 0, 32'h0000_0600, 32'h0, '0},
		'{"rr_ch1", 1, 1'b0, 0, 32'h0000_0200, 32'h0, '0},
		'{"wr_half", 0, 1'b1, 0, 32'h0000_0100, 32'h0000_FFFF, {8{32'h1111_2222}}},
		'{"rd_half", 0, 1'b0, 0, 32'h0000_0108, 32'h0, '0},
		'{"wr_full", 0, 1'b1, 0, 32'h0000_0120, 32'hFFFF_FFFF, {8{32'hCAFE_0042}}},
		'{"rd_burst4", 0, 1'b0, 3, 32'h0000_0100, 32'h0, '0},
		'{"b2b_wr0", 2, 1'b1, 0, 32'h0000_0800, 32'hF0F0_F0F0, {8{32'h3C3C_A5A5}}},
		'{"b2b_rd0", 2, 1'b0, 0, 32'h0000_0800, 32'h0, '0},
		'{"b2b_wr1", 2, 1'b1, 0, 32'h0000_0820, 32'h0000_00FF, {8{32'h0BAD_F00D}}},
		'{"b2b_rd2", 2, 1'b0, 1, 32'h0000_0810, 32'h0, '0},
		'{"wr_lane", 3, 1'b1, 0, 32'h0000_0A04, 32'h0F00_0000, {8{32'h7777_8888}}},
		'{"rd_burst3", 3, 1'b0, 2, 32'h0000_0A00, 32'h0, '0},
		'{"rd_plain", 1, 1'b0, 1, 32'h0000_0300, 32'h0, '0}
	};

	logic mem_ui_clk = 1'b0;
	logic irst;
	logic calib_complete;
	logic app_rdy;
	logic app_wdf_rdy;
	logic app_rd_data_valid;
	mpmc_pkg::strip_t app_rd_data;
	mpmc_pkg::ch_req_t [mpmc_pkg::NUM_CHANNELS-1:0] ch_req;
	logic app_en;
	mpmc_pkg::app_cmd_t app_cmd;
	mpmc_pkg::app_addr_t app_addr;
	mpmc_pkg::strip_t app_wdf_data;
	mpmc_pkg::lane_sel_t app_wdf_mask;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic [mpmc_pkg::NUM_CHANNELS-1:0] ch_credit;
	mpmc_pkg::ch_resp_t [mpmc_pkg::NUM_CHANNELS-1:0] ch_resp;
	mpmc_pkg::mc_state_t state;

	int seed = 91514;
	// memory core contents and the expected contents, one entry per strip
	mpmc_pkg::strip_t model_mem [int unsigned];
	mpmc_pkg::strip_t ref_mem [int unsigned];

	always #20 mem_ui_clk = ~mem_ui_clk;

	mpmc_top UUT (.*);

	mpmc_monitor mon (.mem_ui_clk, .irst, .ch_credit, .ch_resp, .state, .app_en,
		.app_wdf_wren, .app_wdf_end);

	// untouched strips read back a pattern built from the strip number
	function automatic mpmc_pkg::strip_t fill_strip(input int unsigned strip);
		mpmc_pkg::strip_t s;
		for (int w = 0; w < 8; w++)
			s[w*32 +: 32] = (strip * 32'h9E37_79B9) ^ {w[3:0], 28'h5A5_0F3} ^ ~strip;
		return s;
	endfunction

	function automatic mpmc_pkg::strip_t merge(input mpmc_pkg::strip_t old,
		input mpmc_pkg::strip_t nw, input mpmc_pkg::lane_sel_t take_new);
		for (int b = 0; b < mpmc_pkg::MASK_W; b++)
			if (take_new[b])
				old[b*8 +: 8] = nw[b*8 +: 8];
		return old;
	endfunction

	function automatic mpmc_pkg::strip_t ref_read(input int unsigned key);
		return ref_mem.exists(key) ? ref_mem[key] : fill_strip(key);
	endfunction

	function automatic mpmc_pkg::strip_t model_read(input int unsigned key);
		return model_mem.exists(key) ? model_mem[key] : fill_strip(key);
	endfunction

	// ==================================================
	// memory core model
	// ==================================================

	mpmc_pkg::strip_t rd_q [$];
	longint rd_due [$];
	longint cycle = 0;
	longint last_due = 0;
	mpmc_pkg::strip_t wdf_data;
	mpmc_pkg::lane_sel_t wdf_mask;

	always @(posedge mem_ui_clk) begin
		int unsigned key;
		longint due;
		logic beat;
		cycle++;
		if (!irst) begin
			if (app_wdf_wren && app_wdf_rdy) begin
				wdf_data = app_wdf_data;
				wdf_mask = app_wdf_mask;
			end
			if (app_en && app_rdy) begin
				key = {2'b00, app_addr} >> 5;
				if (app_cmd == mpmc_pkg::CMD_WRITE) begin
					model_mem[key] = merge(model_read(key), wdf_data, ~wdf_mask);
				end else begin
					// data comes back in order, 3 to 6 cycles later
					due = cycle + 3 + longint'($random(seed) & 3);
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					rd_q.push_back(model_read(key));
					rd_due.push_back(due);
				end
			end
		end
		beat = (rd_due.size() > 0) && (rd_due[0] <= cycle);
		#2;
		app_rdy = ($random(seed) & 3) != 0;
		app_wdf_rdy = ($random(seed) & 3) != 0;
		app_rd_data_valid = beat;
		if (beat) begin
			app_rd_data = rd_q.pop_front();
			void'(rd_due.pop_front());
		end
	end

	// ==================================================
	// request driver
	// ==================================================

	task automatic apply_entry(input stim_t s);
		mpmc_pkg::ch_req_t r;
		int unsigned key;
		while (mon.credits_left(s.ch) == 0) begin
			@(posedge mem_ui_clk);
			#2;
		end
		r.valid = 1'b1;
		r.we = s.we;
		r.blen = mpmc_pkg::blen_t'(s.blen);
		r.adr = s.adr;
		r.sel = s.sel;
		r.data = s.data;
		ch_req[s.ch] = r;
		mon.note_request(s.ch);
		key = s.adr >> 5;
		if (s.we) begin
			ref_mem[key] = merge(ref_read(key), s.data, s.sel);
			mon.expect_resp(s.ch, s.name, s.adr, '0);
		end else begin
			for (int k = 0; k <= s.blen; k++)
				mon.expect_resp(s.ch, s.name, (key + k) * mpmc_pkg::STRIP_BYTES,
					ref_read(key + k));
		end
		@(posedge mem_ui_clk);
		#2;
		ch_req[s.ch] = '0;
	endtask

	task automatic print_counts();
		$display("errors: monitor %0d, assertions %0d", mon.err_cnt,
			UUT.u_sm.u_checker.fail_cnt);
	endtask

	initial begin
		irst = 1'b1;
		calib_complete = 1'b0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		ch_req = '0;
		// arbiter starts after the last channel, so grants go 0, 1, 2, 3
		for (int k = 1; k <= mpmc_pkg::NUM_CHANNELS; k++)
			mon.expect_order((mpmc_pkg::NUM_CHANNELS - 1 + k) % mpmc_pkg::NUM_CHANNELS);
		repeat (10) @(posedge mem_ui_clk);
		#2;
		mon.check_quiet("reset");
		irst = 1'b0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			apply_entry(stim[i]);
			if (i == RR_ENTRIES - 1) begin
				repeat (5) @(posedge mem_ui_clk);
				#2;
				calib_complete = 1'b1;
			end
		end
		while (mon.exp_ch.size() != 0)
			@(posedge mem_ui_clk);
		repeat (10) @(posedge mem_ui_clk);
		#2;
		mon.check_quiet("final");
		mon.check_credits();
		print_counts();
		if (mon.err_cnt == 0 && UUT.u_sm.u_checker.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (NUM_TESTS * 200) @(posedge mem_ui_clk);
		$display("timeout: %0d responses never arrived", mon.exp_ch.size());
		print_counts();
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* bench/mpmc_checker.sv */
module mpmc_checker (
	input logic mem_ui_clk,
	input logic irst,
	input logic calib_complete,
	input logic app_en,
	input logic app_rdy,
	input logic app_wdf_wren,
	input logic app_wdf_rdy,
	input mpmc_pkg::app_addr_t app_addr
);

	int fail_cnt = 0;

	// a command stays on the bus with a steady address until the core takes it
	a_en_hold: assert property (@(posedge mem_ui_clk) disable iff (irst)
		app_en && !app_rdy |=> app_en && $stable(app_addr))
	else begin
		fail_cnt++;
		$error("app_en dropped or app_addr moved before app_rdy");
	end

	// write strip stays offered until the core takes it
	a_wren_hold: assert property (@(posedge mem_ui_clk) disable iff (irst)
		app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren)
	else begin
		fail_cnt++;
		$error("app_wdf_wren dropped before app_wdf_rdy");
	end

	a_no_cmd_before_calib: assert property (@(posedge mem_ui_clk) disable iff (irst)
		!calib_complete |-> !app_en)
	else begin
		fail_cnt++;
		$error("app_en raised before calibration completed");
	end

endmodule

bind mpmc_state_machine mpmc_checker u_checker (.mem_ui_clk, .irst, .calib_complete,
	.app_en, .app_rdy, .app_wdf_wren, .app_wdf_rdy, .app_addr);

/* bench/mpmc_monitor.sv */
module mpmc_monitor (
	input logic mem_ui_clk,
	input logic irst,
	input logic [mpmc_pkg::NUM_CHANNELS-1:0] ch_credit,
	input mpmc_pkg::ch_resp_t [mpmc_pkg::NUM_CHANNELS-1:0] ch_resp,
	input mpmc_pkg::mc_state_t state,
	input logic app_en,
	input logic app_wdf_wren,
	input logic app_wdf_end
);

	// expected responses, kept in request order across all channels
	int exp_ch [$];
	string exp_name [$];
	logic [31:0] exp_adr [$];
	mpmc_pkg::strip_t exp_data [$];
	// channel order of the first acks
	int order_exp [$];
	int sent [mpmc_pkg::NUM_CHANNELS] = '{default: 0};
	int returned [mpmc_pkg::NUM_CHANNELS] = '{default: 0};
	int err_cnt = 0;

	task automatic expect_resp(input int ch, input string name, input logic [31:0] adr,
		input mpmc_pkg::strip_t data);
		exp_ch.push_back(ch);
		exp_name.push_back(name);
		exp_adr.push_back(adr);
		exp_data.push_back(data);
	endtask

	task automatic expect_order(input int ch);
		order_exp.push_back(ch);
	endtask

	task automatic note_request(input int ch);
		sent[ch]++;
	endtask

	function automatic int credits_left(input int ch);
		return mpmc_pkg::FIFO_DEPTH - sent[ch] + returned[ch];
	endfunction

	task automatic check_credits();
		for (int c = 0; c < mpmc_pkg::NUM_CHANNELS; c++) begin
			if (returned[c] != sent[c]) begin
				err_cnt++;
				$display("channel %0d sent %0d requests but got %0d credits back",
					c, sent[c], returned[c]);
			end
		end
	endtask

	// with nothing in flight the sequencer rests in IDLE and every strobe is low
	task automatic check_quiet(input string name);
		logic [mpmc_pkg::NUM_CHANNELS-1:0] acks;
		for (int c = 0; c < mpmc_pkg::NUM_CHANNELS; c++)
			acks[c] = ch_resp[c].ack;
		if (state !== mpmc_pkg::IDLE) begin
			err_cnt++;
			$display("ERROR %s state expected IDLE actual %s", name, state.name());
		end
		if ({app_en, app_wdf_wren, app_wdf_end, ch_credit, acks} !== '0) begin
			err_cnt++;
			$display("ERROR %s strobes expected 0 actual %b", name,
				{app_en, app_wdf_wren, app_wdf_end, ch_credit, acks});
		end
	endtask

	// ==================================================
	// response compare
	// ==================================================

	always @(posedge mem_ui_clk) begin
		int idx;
		if (!irst) begin
			// every write is one strip, so each strip offered is also the last
			if (app_wdf_end !== app_wdf_wren) begin
				err_cnt++;
				$display("app_wdf_end does not follow app_wdf_wren of a one strip write");
			end
			for (int c = 0; c < mpmc_pkg::NUM_CHANNELS; c++) begin
				if (ch_credit[c]) begin
					returned[c]++;
					if (returned[c] > sent[c]) begin
						err_cnt++;
						$display("channel %0d got more credits back than requests sent", c);
					end
				end
				if (ch_resp[c].ack) begin
					if (order_exp.size() > 0) begin
						if (order_exp[0] != c) begin
							err_cnt++;
							$display("ERROR rr_order expected ch %0d actual ch %0d",
								order_exp[0], c);
						end
						void'(order_exp.pop_front());
					end
					// oldest outstanding response of this channel
					idx = -1;
					for (int i = exp_ch.size() - 1; i >= 0; i--)
						if (exp_ch[i] == c)
							idx = i;
					if (idx < 0) begin
						err_cnt++;
						$display("channel %0d acked with no request outstanding", c);
					end else begin
						if (ch_resp[c].adr !== exp_adr[idx]) begin
							err_cnt++;
							$display("ERROR %s adr expected %h actual %h", exp_name[idx],
								exp_adr[idx], ch_resp[c].adr);
						end
						if (ch_resp[c].data !== exp_data[idx]) begin
							err_cnt++;
							$display("ERROR %s data expected %h actual %h", exp_name[idx],
								exp_data[idx], ch_resp[c].data);
						end
						exp_ch.delete(idx);
						exp_name.delete(idx);
						exp_adr.delete(idx);
						exp_data.delete(idx);
					end
				end
			end
		end
	end

endmodule

/* logic/mpmc_top.sv */
module mpmc_top (
	input logic mem_ui_clk,
	input logic irst,
	input logic calib_complete,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	input mpmc_pkg::strip_t app_rd_data,
	input mpmc_pkg::ch_req_t [mpmc_pkg::NUM_CHANNELS-1:0] ch_req,
	output logic app_en,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::app_addr_t app_addr,
	output mpmc_pkg::strip_t app_wdf_data,
	output mpmc_pkg::lane_sel_t app_wdf_mask,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output logic [mpmc_pkg::NUM_CHANNELS-1:0] ch_credit,
	output mpmc_pkg::ch_resp_t [mpmc_pkg::NUM_CHANNELS-1:0] ch_resp,
	output mpmc_pkg::mc_state_t state
);

	mpmc_pkg::fifo_entry_t [mpmc_pkg::NUM_CHANNELS-1:0] fifo_head;
	logic [mpmc_pkg::NUM_CHANNELS-1:0] not_empty;
	logic [mpmc_pkg::NUM_CHANNELS-1:0] rr_pop;
	mpmc_pkg::ch_idx_t rr_sel;
	logic grant_en;
	mpmc_pkg::fifo_entry_t sm_head;
	mpmc_pkg::fifo_entry_t cur;
	mpmc_pkg::byte_addr_t beat_adr;
	logic wr_done;

	// ==================================================
	// request fifos and arbiter
	// ==================================================

	for (genvar g = 0; g < mpmc_pkg::NUM_CHANNELS; g++) begin : g_fifo
		mpmc_req_fifo u_fifo (.mem_ui_clk, .irst, .req(ch_req[g]),
			.ch(mpmc_pkg::ch_idx_t'(g)), .pop(rr_pop[g]), .head(fifo_head[g]),
			.not_empty(not_empty[g]), .credit(ch_credit[g]));
	end

	mpmc_round_robin u_rr (.mem_ui_clk, .irst, .req(not_empty), .grant_en,
		.pop(rr_pop), .sel(rr_sel));

	// head of the channel the arbiter is pointing at
	assign sm_head = fifo_head[rr_sel];

	// ==================================================
	// sequencer and responses
	// ==================================================

	mpmc_state_machine u_sm (.mem_ui_clk, .irst, .calib_complete, .head(sm_head),
		.app_rdy, .app_wdf_rdy, .app_rd_data_valid, .grant_en, .cur, .state, .app_en,
		.app_cmd, .app_addr, .app_wdf_data, .app_wdf_mask, .app_wdf_wren, .app_wdf_end,
		.beat_adr, .wr_done);

	mpmc_resp_router u_router (.mem_ui_clk, .irst, .cur, .beat_adr, .wr_done,
		.app_rd_data_valid, .app_rd_data, .ch_resp);

endmodule

/* logic/mpmc_resp_router.sv */
module mpmc_resp_router (
	input logic mem_ui_clk,
	input logic irst,
	input mpmc_pkg::fifo_entry_t cur,
	input mpmc_pkg::byte_addr_t beat_adr,
	input logic wr_done,
	input logic app_rd_data_valid,
	input mpmc_pkg::strip_t app_rd_data,
	output mpmc_pkg::ch_resp_t [mpmc_pkg::NUM_CHANNELS-1:0] ch_resp
);

	logic ack_q;
	mpmc_pkg::ch_idx_t ch_q;
	mpmc_pkg::byte_addr_t adr_q;
	mpmc_pkg::strip_t data_q;

	always_ff @(posedge mem_ui_clk) begin
		if (irst)
			ack_q <= 1'b0;
		else
			ack_q <= app_rd_data_valid | wr_done;
	end

	// read beat or write completion, never both in one cycle
	always_ff @(posedge mem_ui_clk) begin
		if (app_rd_data_valid) begin
			data_q <= app_rd_data;
			adr_q <= beat_adr;
			ch_q <= cur.ch;
		end else if (wr_done) begin
			data_q <= '0;
			adr_q <= cur.req.adr;
			ch_q <= cur.ch;
		end
	end

	// payload is shared, only the served channel sees ack
	always_comb begin
		for (int i = 0; i < mpmc_pkg::NUM_CHANNELS; i++) begin
			ch_resp[i].ack = ack_q && (ch_q == mpmc_pkg::ch_idx_t'(i));
			ch_resp[i].adr = adr_q;
			ch_resp[i].data = data_q;
		end
	end

endmodule

/* logic/mpmc_state_machine.sv */
module mpmc_state_machine (
	input logic mem_ui_clk,
	input logic irst,
	input logic calib_complete,
	input mpmc_pkg::fifo_entry_t head,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	output logic grant_en,
	output mpmc_pkg::fifo_entry_t cur,
	output mpmc_pkg::mc_state_t state,
	output logic app_en,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::app_addr_t app_addr,
	output mpmc_pkg::strip_t app_wdf_data,
	output mpmc_pkg::lane_sel_t app_wdf_mask,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output mpmc_pkg::byte_addr_t beat_adr,
	output logic wr_done
);

	// commands issued and beats returned
	mpmc_pkg::blen_t req_cnt;
	mpmc_pkg::blen_t resp_cnt;
	// write strip already taken by the core
	logic wdf_sent;
	mpmc_pkg::byte_addr_t strip_base;
	mpmc_pkg::byte_addr_t req_adr;
	logic cmd_accept;

	// ==================================================
	// addresses
	// ==================================================

	assign strip_base = cur.req.adr & ~mpmc_pkg::byte_addr_t'(mpmc_pkg::STRIP_BYTES - 1);
	assign req_adr = strip_base + mpmc_pkg::byte_addr_t'(req_cnt) * mpmc_pkg::STRIP_BYTES;
	assign beat_adr = strip_base + mpmc_pkg::byte_addr_t'(resp_cnt) * mpmc_pkg::STRIP_BYTES;
	assign app_addr = req_adr[mpmc_pkg::APP_ADDR_W-1:0];

	// ==================================================
	// memory core interface
	// ==================================================

	assign grant_en = (state == mpmc_pkg::IDLE) && calib_complete;

	// data goes first, the write command follows once it is taken
	assign app_wdf_wren = (state == mpmc_pkg::ISSUE_WRITE) && !wdf_sent;
	assign app_wdf_end = app_wdf_wren;
	assign app_wdf_data = cur.req.data;
	assign app_wdf_mask = ~cur.req.sel;

	assign app_en = ((state == mpmc_pkg::ISSUE_WRITE) && wdf_sent) ||
		(state == mpmc_pkg::ISSUE_READ);
	assign app_cmd = cur.req.we ? mpmc_pkg::CMD_WRITE : mpmc_pkg::CMD_READ;

	assign cmd_accept = app_en && app_rdy;
	assign wr_done = cmd_accept && (state == mpmc_pkg::ISSUE_WRITE);

	// granted entry is held for the whole transaction
	always_ff @(posedge mem_ui_clk) begin
		if (grant_en && head.req.valid)
			cur <= head;
	end

	// ==================================================
	// sequencer
	// ==================================================

	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			state <= mpmc_pkg::IDLE;
			wdf_sent <= 1'b0;
			req_cnt <= '0;
			resp_cnt <= '0;
		end else begin
			case (state)
			mpmc_pkg::IDLE: begin
				if (grant_en && head.req.valid) begin
					state <= head.req.we ? mpmc_pkg::ISSUE_WRITE : mpmc_pkg::ISSUE_READ;
					wdf_sent <= 1'b0;
					req_cnt <= '0;
					resp_cnt <= '0;
				end
			end
			mpmc_pkg::ISSUE_WRITE: begin
				if (!wdf_sent) begin
					if (app_wdf_rdy)
						wdf_sent <= 1'b1;
				end else if (app_rdy) begin
					state <= mpmc_pkg::DONE;
				end
			end
			mpmc_pkg::ISSUE_READ: begin
				// early beats may come back while commands are still going out
				if (app_rd_data_valid)
					resp_cnt <= resp_cnt + 1'b1;
				if (app_rdy) begin
					if (req_cnt == cur.req.blen)
						state <= mpmc_pkg::WAIT_READ;
					else
						req_cnt <= req_cnt + 1'b1;
				end
			end
			mpmc_pkg::WAIT_READ: begin
				if (app_rd_data_valid) begin
					if (resp_cnt == cur.req.blen)
						state <= mpmc_pkg::DONE;
					else
						resp_cnt <= resp_cnt + 1'b1;
				end
			end
			mpmc_pkg::DONE: state <= mpmc_pkg::IDLE;
			default: state <= mpmc_pkg::IDLE;
			endcase
		end
	end

endmodule

/* logic/mpmc_round_robin.sv */
module mpmc_round_robin (
	input logic mem_ui_clk,
	input logic irst,
	input logic [mpmc_pkg::NUM_CHANNELS-1:0] req,
	input logic grant_en,
	output logic [mpmc_pkg::NUM_CHANNELS-1:0] pop,
	output mpmc_pkg::ch_idx_t sel
);

	mpmc_pkg::ch_idx_t last;
	mpmc_pkg::ch_idx_t idx;
	logic found;

	// scan starts just after the last grant and ends on it
	always_comb begin
		sel = last;
		found = 1'b0;
		idx = last;
		for (int i = 1; i <= mpmc_pkg::NUM_CHANNELS; i++) begin
			idx = last + mpmc_pkg::ch_idx_t'(i);
			if (!found && req[idx]) begin
				sel = idx;
				found = 1'b1;
			end
		end
		pop = '0;
		if (grant_en && found)
			pop[sel] = 1'b1;
	end

	// after reset channel 0 is first in line
	always_ff @(posedge mem_ui_clk) begin
		if (irst)
			last <= mpmc_pkg::ch_idx_t'(mpmc_pkg::NUM_CHANNELS - 1);
		else if (grant_en && found)
			last <= sel;
	end

endmodule

/* logic/mpmc_req_fifo.sv */
module mpmc_req_fifo (
	input logic mem_ui_clk,
	input logic irst,
	input mpmc_pkg::ch_req_t req,
	input mpmc_pkg::ch_idx_t ch,
	input logic pop,
	output mpmc_pkg::fifo_entry_t head,
	output logic not_empty,
	output logic credit
);

	typedef logic [mpmc_pkg::FIFO_PTR_W-1:0] ptr_t;

	mpmc_pkg::fifo_entry_t mem [mpmc_pkg::FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	logic [mpmc_pkg::FIFO_PTR_W:0] count;
	logic push;

	// credits guarantee room, so a valid request always lands
	assign push = req.valid;
	assign not_empty = (count != '0);

	always_ff @(posedge mem_ui_clk) begin
		if (push) begin
			mem[wr_ptr].req <= req;
			mem[wr_ptr].ch <= ch;
		end
	end

	// depth is a power of two, pointers wrap on their own
	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
			endcase
			// one credit back per popped entry
			credit <= pop;
		end
	end

	// stale entries never look valid
	always_comb begin
		head = mem[rd_ptr];
		head.req.valid = mem[rd_ptr].req.valid & not_empty;
	end

endmodule

/* logic/mpmc_pkg.sv */
package mpmc_pkg;

	// ==================================================
	// sizes
	// ==================================================

	localparam int NUM_CHANNELS = 4;
	localparam int CH_IDX_W = 2;

	// request fifo entries, also the credits each client starts with
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	localparam int DATA_W = 256;
	localparam int MASK_W = 32;
	localparam int unsigned STRIP_BYTES = 32;

	localparam int BYTE_ADDR_W = 32;
	localparam int APP_ADDR_W = 30;
	localparam int BLEN_W = 2;
	localparam int APP_CMD_W = 3;

	// app_cmd codes of the memory core
	localparam logic [APP_CMD_W-1:0] CMD_WRITE = 3'd0;
	localparam logic [APP_CMD_W-1:0] CMD_READ = 3'd1;

	// ==================================================
	// types
	// ==================================================

	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	typedef logic [APP_ADDR_W-1:0] app_addr_t;
	typedef logic [DATA_W-1:0] strip_t;
	typedef logic [MASK_W-1:0] lane_sel_t;
	// beats minus one
	typedef logic [BLEN_W-1:0] blen_t;
	typedef logic [CH_IDX_W-1:0] ch_idx_t;
	typedef logic [APP_CMD_W-1:0] app_cmd_t;

	// one client request, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic we;
		blen_t blen;
		byte_addr_t adr;
		lane_sel_t sel;
		strip_t data;
	} ch_req_t;

	// one response beat, ack lasts one cycle
	typedef struct packed {
		logic ack;
		byte_addr_t adr;
		strip_t data;
	} ch_resp_t;

	// request plus the channel it came from
	typedef struct packed {
		ch_req_t req;
		ch_idx_t ch;
	} fifo_entry_t;

	typedef enum logic [2:0] {
		IDLE,
		ISSUE_WRITE,
		ISSUE_READ,
		WAIT_READ,
		DONE
	} mc_state_t;

endpackage
